//--- include/cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// address split 20 + 8 + 4
`define CACHE_TAG_W 20
`define CACHE_INDEX_W 8
`define CACHE_OFFSET_W 4

// one bank word and its byte strobe
`define CACHE_DATA_W 64
`define CACHE_STRB_W 8

// 16-byte block held as two bank words
`define CACHE_BANKS 2
`define CACHE_WAYS 2

// victim selection LFSR, Galois form
`define CACHE_LFSR_W 16
`define CACHE_LFSR_TAPS 16'hb400
`define CACHE_LFSR_SEED 16'h9c35

`endif

//--- hdl/cache_pkg.sv
`include "cache_defines.svh"

package cache_pkg;

	typedef logic [`CACHE_TAG_W+`CACHE_INDEX_W+`CACHE_OFFSET_W-1:0] addr_t;
	typedef logic [`CACHE_TAG_W-1:0] tag_t;
	typedef logic [`CACHE_INDEX_W-1:0] index_t;
	typedef logic [`CACHE_DATA_W-1:0] word_t;
	typedef logic [`CACHE_STRB_W-1:0] strb_t;

	// valid bit sits above the tag
	typedef struct packed {
		logic valid;
		tag_t tag;
	} tag_entry_t;

	// bank 0 in the low bits, i.e. the lower address
	typedef logic [`CACHE_BANKS*`CACHE_DATA_W-1:0] block_t;

	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		WRITEBACK,
		REFILL_REQ,
		REFILL,
		RESPOND
	} ctrl_state_t;

endpackage

//--- hdl/sync_ram.sv
module sync_ram #(
	parameter type entry_t = logic,
	parameter int DEPTH = 256
) (
	input logic clk,
	input logic en,
	input logic we,
	input cache_pkg::index_t addr,
	input cache_pkg::strb_t wstrb,
	input entry_t din,
	output entry_t dout
);
	localparam int W = $bits(entry_t);
	localparam int NB = W / 8;

	logic [W-1:0] mem [DEPTH];
	logic [W-1:0] din_bits;
	logic [W-1:0] rd_q;

	assign din_bits = din;

	generate
		if (W % 8 == 0) begin : g_byte_wr
			// byte lanes follow the strobe
			always_ff @(posedge clk) begin
				if (en && we) begin
					for (int b = 0; b < NB; b++) begin
						if (wstrb[b])
							mem[addr][b*8 +: 8] <= din_bits[b*8 +: 8];
					end
				end
			end
		end else begin : g_full_wr
			always_ff @(posedge clk) begin
				if (en && we)
					mem[addr] <= din_bits;
			end
		end
	endgenerate

	// registered read, old data kept on a write cycle
	always_ff @(posedge clk) begin
		if (en && !we)
			rd_q <= mem[addr];
	end

	assign dout = entry_t'(rd_q);

	a_we_needs_en: assert property (@(posedge clk) we |-> en)
		else $error("sync_ram write without enable");

endmodule

//--- hdl/cache_way.sv
`include "cache_defines.svh"

module cache_way (
	input logic clk,
	input logic tag_en,
	input logic tag_we,
	input logic dirty_we,
	input logic dirty_din,
	input logic [`CACHE_BANKS-1:0] bank_en,
	input logic [`CACHE_BANKS-1:0] bank_we,
	input cache_pkg::index_t tag_index,
	input cache_pkg::index_t bank_index,
	input cache_pkg::tag_entry_t tag_din,
	input cache_pkg::strb_t bank_wstrb,
	input cache_pkg::word_t bank_din,
	input cache_pkg::tag_t lookup_tag,
	output logic hit,
	output logic dirty,
	output cache_pkg::tag_entry_t entry,
	output cache_pkg::block_t block
);
	localparam int DEPTH = 1 << `CACHE_INDEX_W;

	cache_pkg::word_t bank_dout [`CACHE_BANKS];
	cache_pkg::index_t dirty_index;

	sync_ram #(.entry_t(cache_pkg::tag_entry_t), .DEPTH(DEPTH)) i_tag_ram (
		.clk(clk),
		.en(tag_en),
		.we(tag_we),
		.addr(tag_index),
		.wstrb({`CACHE_STRB_W{1'b1}}),
		.din(tag_din),
		.dout(entry)
	);

	// dirty is read with the tag, written with a bank commit or a refill
	assign dirty_index = dirty_we ? bank_index : tag_index;

	sync_ram #(.entry_t(logic), .DEPTH(DEPTH)) i_dirty_ram (
		.clk(clk),
		.en(tag_en | dirty_we),
		.we(dirty_we),
		.addr(dirty_index),
		.wstrb({`CACHE_STRB_W{1'b1}}),
		.din(dirty_din),
		.dout(dirty)
	);

	for (genvar b = 0; b < `CACHE_BANKS; b++) begin : g_bank
		sync_ram #(.entry_t(cache_pkg::word_t), .DEPTH(DEPTH)) i_bank_ram (
			.clk(clk),
			.en(bank_en[b]),
			.we(bank_we[b]),
			.addr(bank_index),
			.wstrb(bank_wstrb),
			.din(bank_din),
			.dout(bank_dout[b])
		);
		assign block[b*`CACHE_DATA_W +: `CACHE_DATA_W] = bank_dout[b];
	end

	assign hit = entry.valid && (entry.tag == lookup_tag);

endmodule

//--- hdl/store_buffer.sv
module store_buffer (
	input logic clk,
	input logic rst,
	input logic sb_load,
	input logic load_way,
	input cache_pkg::index_t load_index,
	input logic load_word,
	input cache_pkg::strb_t load_strb,
	input cache_pkg::word_t load_data,
	output logic sb_pending,
	output cache_pkg::index_t sb_index,
	output logic sb_word,
	output logic sb_way,
	output cache_pkg::strb_t sb_strb,
	output cache_pkg::word_t sb_data
);

	// a pending entry always commits in its first cycle
	always_ff @(posedge clk) begin
		if (rst)
			sb_pending <= 1'b0;
		else
			sb_pending <= sb_load;
	end

	always_ff @(posedge clk) begin
		if (sb_load) begin
			sb_way <= load_way;
			sb_index <= load_index;
			sb_word <= load_word;
			sb_strb <= load_strb;
			sb_data <= load_data;
		end
	end

	// controller must not replace a commit aimed at another word
	a_no_overwrite: assert property (@(posedge clk) disable iff (rst)
		sb_load && sb_pending |-> (load_index == sb_index) && (load_word == sb_word))
		else $error("store buffer reloaded over a different pending word");

endmodule

//--- hdl/cache_ctrl.sv
`include "cache_defines.svh"

module cache_ctrl (
	input logic clk,
	input logic rst,
	input logic req_valid,
	input logic req_write,
	input cache_pkg::addr_t req_addr,
	input cache_pkg::strb_t req_wstrb,
	input cache_pkg::word_t req_wdata,
	output logic req_ready,
	output logic resp_valid,
	output cache_pkg::word_t resp_data,
	input logic resp_ready,
	output logic rd_valid,
	output cache_pkg::addr_t rd_addr,
	input logic rd_ready,
	input logic rd_data_valid,
	input logic rd_data_last,
	input cache_pkg::word_t rd_data,
	output logic wb_valid,
	output cache_pkg::addr_t wb_addr,
	output cache_pkg::block_t wb_data,
	input logic wb_ready,
	input logic [`CACHE_WAYS-1:0] way_hit,
	input logic [`CACHE_WAYS-1:0] way_dirty,
	input cache_pkg::tag_entry_t way_entry [`CACHE_WAYS],
	input cache_pkg::block_t way_block [`CACHE_WAYS],
	input logic sb_pending,
	input cache_pkg::index_t sb_index,
	input logic sb_word,
	output logic [`CACHE_WAYS-1:0] tag_en,
	output logic [`CACHE_WAYS-1:0] tag_we,
	output logic [`CACHE_WAYS-1:0] dirty_we,
	output logic [`CACHE_WAYS-1:0] dirty_din,
	output logic [`CACHE_BANKS-1:0] bank_en [`CACHE_WAYS],
	output logic [`CACHE_BANKS-1:0] bank_we [`CACHE_WAYS],
	output cache_pkg::index_t tag_index,
	output cache_pkg::index_t bank_index,
	output cache_pkg::tag_entry_t tag_din,
	output cache_pkg::strb_t bank_wstrb,
	output cache_pkg::word_t bank_din,
	output cache_pkg::tag_t lookup_tag,
	output logic sb_load,
	output logic load_way,
	output cache_pkg::index_t load_index,
	output logic load_word,
	output cache_pkg::strb_t load_strb,
	output cache_pkg::word_t load_data
);
	localparam int TAG_LO = `CACHE_OFFSET_W + `CACHE_INDEX_W;

	cache_pkg::ctrl_state_t state, state_next;
	cache_pkg::tag_t req_tag, rb_tag;
	cache_pkg::index_t req_index, rb_index, mb_index;
	cache_pkg::strb_t rb_strb;
	cache_pkg::word_t rb_wdata, merged;
	cache_pkg::tag_entry_t mb_entry;
	cache_pkg::block_t mb_block;
	logic [`CACHE_LFSR_W-1:0] lfsr;
	logic req_word, rb_word, rb_write;
	logic accept, conflict, hit, hit_way, victim, victim_dirty;
	logic mb_way, beat, refill_beat;

	assign req_tag = req_addr[TAG_LO +: `CACHE_TAG_W];
	assign req_index = req_addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
	assign req_word = req_addr[`CACHE_OFFSET_W-1];

	// a load of the word the store buffer is writing waits one cycle
	assign conflict = req_valid && !req_write && sb_pending &&
		(req_index == sb_index) && (req_word == sb_word);
	assign req_ready = (state == cache_pkg::IDLE) && !conflict;
	assign accept = req_valid && req_ready;

	assign hit = |way_hit;
	// two ways, so the upper flag names the hit way
	assign hit_way = way_hit[1];
	assign victim = lfsr[0];
	assign victim_dirty = way_entry[victim].valid && way_dirty[victim];
	assign refill_beat = (state == cache_pkg::REFILL) && rd_data_valid;

	always_comb begin
		state_next = state;
		case (state)
			cache_pkg::IDLE:
				if (accept)
					state_next = cache_pkg::LOOKUP;
			cache_pkg::LOOKUP:
				if (hit)
					state_next = cache_pkg::RESPOND;
				else if (victim_dirty)
					state_next = cache_pkg::WRITEBACK;
				else
					state_next = cache_pkg::REFILL_REQ;
			cache_pkg::WRITEBACK:
				if (wb_ready)
					state_next = cache_pkg::REFILL_REQ;
			cache_pkg::REFILL_REQ:
				if (rd_ready)
					state_next = cache_pkg::REFILL;
			cache_pkg::REFILL:
				if (refill_beat && rd_data_last)
					state_next = cache_pkg::RESPOND;
			cache_pkg::RESPOND:
				if (resp_ready)
					state_next = cache_pkg::IDLE;
			default:
				state_next = cache_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= cache_pkg::IDLE;
		else
			state <= state_next;
	end

	// stepped once per miss
	always_ff @(posedge clk) begin
		if (rst)
			lfsr <= `CACHE_LFSR_SEED;
		else if (state == cache_pkg::LOOKUP && !hit)
			lfsr <= (lfsr >> 1) ^ ({`CACHE_LFSR_W{lfsr[0]}} & `CACHE_LFSR_TAPS);
	end

	always_ff @(posedge clk) begin
		if (rst || state != cache_pkg::REFILL)
			beat <= 1'b0;
		else if (rd_data_valid)
			beat <= beat + 1'b1;
	end

	// request buffer
	always_ff @(posedge clk) begin
		if (accept) begin
			rb_write <= req_write;
			rb_tag <= req_tag;
			rb_index <= req_index;
			rb_word <= req_word;
			rb_strb <= req_wstrb;
			rb_wdata <= req_wdata;
		end
	end

	// miss buffer holds the victim for write-back and refill
	always_ff @(posedge clk) begin
		if (state == cache_pkg::LOOKUP && !hit) begin
			mb_way <= victim;
			mb_index <= rb_index;
			mb_entry <= way_entry[victim];
			mb_block <= way_block[victim];
		end
	end

	always_ff @(posedge clk) begin
		if (state == cache_pkg::LOOKUP && hit && !rb_write)
			resp_data <= way_block[hit_way][rb_word*`CACHE_DATA_W +: `CACHE_DATA_W];
		else if (refill_beat && beat == rb_word)
			resp_data <= rd_data;
	end

	// write-allocate merge of the store bytes into the fetched word
	always_comb begin
		for (int b = 0; b < `CACHE_STRB_W; b++)
			merged[b*8 +: 8] = rb_strb[b] ? rb_wdata[b*8 +: 8] : rd_data[b*8 +: 8];
	end

	always_comb begin
		tag_en = '0;
		tag_we = '0;
		dirty_we = '0;
		dirty_din = '0;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			bank_en[w] = '0;
			bank_we[w] = '0;
		end
		tag_index = req_index;
		bank_index = req_index;
		tag_din = '{valid: 1'b1, tag: rb_tag};
		bank_wstrb = {`CACHE_STRB_W{1'b1}};
		bank_din = (rb_write && beat == rb_word) ? merged : rd_data;
		if (accept) begin
			// full read for lookup and a possible write-back
			tag_en = '1;
			for (int w = 0; w < `CACHE_WAYS; w++)
				bank_en[w] = '1;
		end
		if (refill_beat) begin
			tag_index = mb_index;
			bank_index = mb_index;
			bank_en[mb_way][beat] = 1'b1;
			bank_we[mb_way][beat] = 1'b1;
			if (rd_data_last) begin
				tag_en[mb_way] = 1'b1;
				tag_we[mb_way] = 1'b1;
				dirty_we[mb_way] = 1'b1;
				dirty_din[mb_way] = rb_write;
			end
		end
	end

	assign lookup_tag = rb_tag;

	assign sb_load = (state == cache_pkg::LOOKUP) && hit && rb_write;
	assign load_way = hit_way;
	assign load_index = rb_index;
	assign load_word = rb_word;
	assign load_strb = rb_strb;
	assign load_data = rb_wdata;

	assign resp_valid = (state == cache_pkg::RESPOND);
	assign rd_valid = (state == cache_pkg::REFILL_REQ);
	assign rd_addr = {rb_tag, rb_index, {`CACHE_OFFSET_W{1'b0}}};
	assign wb_valid = (state == cache_pkg::WRITEBACK);
	assign wb_addr = {mb_entry.tag, mb_index, {`CACHE_OFFSET_W{1'b0}}};
	assign wb_data = mb_block;

	a_resp_hold: assert property (@(posedge clk) disable iff (rst)
		resp_valid && !resp_ready |=> resp_valid && $stable(resp_data))
		else $error("response dropped before resp_ready");

	a_beat_in_refill: assert property (@(posedge clk) disable iff (rst)
		rd_data_valid |-> state == cache_pkg::REFILL)
		else $error("refill beat outside REFILL");

endmodule

//--- hdl/cache_top.sv
`include "cache_defines.svh"

module cache_top (
	input logic clk,
	input logic rst,
	input logic req_valid,
	input logic req_write,
	input cache_pkg::addr_t req_addr,
	input cache_pkg::strb_t req_wstrb,
	input cache_pkg::word_t req_wdata,
	output logic req_ready,
	output logic resp_valid,
	output cache_pkg::word_t resp_data,
	input logic resp_ready,
	output logic rd_valid,
	output cache_pkg::addr_t rd_addr,
	input logic rd_ready,
	input logic rd_data_valid,
	input logic rd_data_last,
	input cache_pkg::word_t rd_data,
	output logic wb_valid,
	output cache_pkg::addr_t wb_addr,
	output cache_pkg::block_t wb_data,
	input logic wb_ready
);
	logic [`CACHE_WAYS-1:0] way_hit, way_dirty;
	cache_pkg::tag_entry_t way_entry [`CACHE_WAYS];
	cache_pkg::block_t way_block [`CACHE_WAYS];

	logic [`CACHE_WAYS-1:0] tag_en, tag_we, dirty_we, dirty_din;
	logic [`CACHE_BANKS-1:0] bank_en [`CACHE_WAYS];
	logic [`CACHE_BANKS-1:0] bank_we [`CACHE_WAYS];
	cache_pkg::index_t tag_index, bank_index;
	cache_pkg::tag_entry_t tag_din;
	cache_pkg::strb_t bank_wstrb;
	cache_pkg::word_t bank_din;
	cache_pkg::tag_t lookup_tag;

	logic sb_load, load_way, load_word;
	cache_pkg::index_t load_index;
	cache_pkg::strb_t load_strb;
	cache_pkg::word_t load_data;
	logic sb_pending, sb_word, sb_way;
	cache_pkg::index_t sb_index;
	cache_pkg::strb_t sb_strb;
	cache_pkg::word_t sb_data;

	cache_ctrl i_cache_ctrl (.*);

	store_buffer i_store_buffer (.*);

	for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
		logic [`CACHE_BANKS-1:0] w_bank_en, w_bank_we;
		logic w_dirty_we, w_dirty_din;
		cache_pkg::index_t w_bank_index;
		cache_pkg::strb_t w_bank_wstrb;
		cache_pkg::word_t w_bank_din;

		// store commit takes the bank port of its own way
		always_comb begin
			w_bank_en = bank_en[w];
			w_bank_we = bank_we[w];
			w_dirty_we = dirty_we[w];
			w_dirty_din = dirty_din[w];
			w_bank_index = bank_index;
			w_bank_wstrb = bank_wstrb;
			w_bank_din = bank_din;
			if (sb_pending && sb_way == 1'(w)) begin
				w_bank_en[sb_word] = 1'b1;
				w_bank_we[sb_word] = 1'b1;
				w_dirty_we = 1'b1;
				w_dirty_din = 1'b1;
				w_bank_index = sb_index;
				w_bank_wstrb = sb_strb;
				w_bank_din = sb_data;
			end
		end

		cache_way i_cache_way (
			.clk(clk),
			.tag_en(tag_en[w]),
			.tag_we(tag_we[w]),
			.dirty_we(w_dirty_we),
			.dirty_din(w_dirty_din),
			.bank_en(w_bank_en),
			.bank_we(w_bank_we),
			.tag_index(tag_index),
			.bank_index(w_bank_index),
			.tag_din(tag_din),
			.bank_wstrb(w_bank_wstrb),
			.bank_din(w_bank_din),
			.lookup_tag(lookup_tag),
			.hit(way_hit[w]),
			.dirty(way_dirty[w]),
			.entry(way_entry[w]),
			.block(way_block[w])
		);
	end

endmodule

//--- sim/tb_cache.sv
module tb_cache;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 20;
	localparam int STIM_MAX = 64;
	localparam int CYCLES_PER_OP = 400;

	logic clk;
	logic rst;
	logic req_valid;
	logic req_write;
	cache_pkg::addr_t req_addr;
	cache_pkg::strb_t req_wstrb;
	cache_pkg::word_t req_wdata;
	logic req_ready;
	logic resp_valid;
	cache_pkg::word_t resp_data;
	logic resp_ready;
	logic rd_valid;
	cache_pkg::addr_t rd_addr;
	logic rd_ready;
	logic rd_data_valid;
	logic rd_data_last;
	cache_pkg::word_t rd_data;
	logic wb_valid;
	cache_pkg::addr_t wb_addr;
	cache_pkg::block_t wb_data;
	logic wb_ready;

	// five words per operation: op, address, strobe, store data, expected data
	logic [63:0] stim [STIM_MAX*5];
	int n_ops = 0;
	int data_errors = 0;
	int proto_errors = 0;
	logic [31:0] lfsr_q = 32'hcf65;
	cache_pkg::addr_t cur_addr = '0;

	// memory contents and the processor's view of every word
	cache_pkg::word_t mem_model [cache_pkg::addr_t];
	cache_pkg::word_t shadow [cache_pkg::addr_t];

	cache_top i_cache_top (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
	endfunction

	function automatic logic next_random_bit();
		logic b;
		b = lfsr_q[0];
		lfsr_q = lfsr_step(lfsr_q);
		return b;
	endfunction

	// word never written: upper half is cafe0000 plus the address's upper half
	function automatic cache_pkg::word_t initial_word(input cache_pkg::addr_t a);
		cache_pkg::addr_t wa;
		wa = {a[31:3], 3'b000};
		return {32'hcafe0000 + {16'h0000, wa[31:16]}, wa};
	endfunction

	function automatic cache_pkg::word_t memory_word(input cache_pkg::addr_t a);
		cache_pkg::addr_t wa;
		wa = {a[31:3], 3'b000};
		if (mem_model.exists(wa))
			return mem_model[wa];
		return initial_word(wa);
	endfunction

	function automatic cache_pkg::word_t current_word(input cache_pkg::addr_t a);
		cache_pkg::addr_t wa;
		wa = {a[31:3], 3'b000};
		if (shadow.exists(wa))
			return shadow[wa];
		return initial_word(wa);
	endfunction

	function automatic cache_pkg::word_t apply_strobe(input cache_pkg::word_t old,
			input cache_pkg::word_t data, input cache_pkg::strb_t strb);
		cache_pkg::word_t res;
		res = old;
		for (int b = 0; b < 8; b++) begin
			if (strb[b])
				res[b*8 +: 8] = data[b*8 +: 8];
		end
		return res;
	endfunction

	task automatic report_counts();
		$display("data errors: %0d, protocol errors: %0d", data_errors, proto_errors);
	endtask

	// dirty victim must carry the latest stored value of both words
	task automatic check_writeback();
		cache_pkg::addr_t base;
		cache_pkg::word_t lo;
		cache_pkg::word_t hi;
		base = wb_addr;
		lo = current_word(base);
		hi = current_word(base + 32'd8);
		assert (base[3:0] == 4'h0) else begin
			$display("write-back address 0x%08h is not block aligned", base);
			proto_errors++;
		end
		assert (wb_data == {hi, lo}) else begin
			$display("CHECK FAILED at %0d ns: write-back to 0x%08h carried 0x%032h, expected 0x%032h",
				$time, base, wb_data, {hi, lo});
			data_errors++;
		end
		mem_model[base] = wb_data[63:0];
		mem_model[base + 32'd8] = wb_data[127:64];
	endtask

	task automatic run_op(input int idx);
		logic [63:0] op;
		cache_pkg::addr_t addr;
		cache_pkg::strb_t strb;
		cache_pkg::word_t wdata;
		cache_pkg::word_t expect_data;
		logic write;
		logic must_hit;
		logic saw_mem;
		logic done;
		int wait_n;
		int first_resp;
		op = stim[idx*5];
		addr = stim[idx*5+1][31:0];
		strb = stim[idx*5+2][7:0];
		wdata = stim[idx*5+3];
		expect_data = stim[idx*5+4];
		write = op[0];
		must_hit = op[1];
		@(posedge clk);
		#1;
		req_valid = 1'b1;
		req_write = write;
		req_addr = addr;
		req_wstrb = strb;
		req_wdata = wdata;
		do
			@(negedge clk);
		while (!req_ready);
		@(posedge clk);
		#1;
		req_valid = 1'b0;
		cur_addr = addr;
		if (write)
			shadow[{addr[31:3], 3'b000}] = apply_strobe(current_word(addr), wdata, strb);
		saw_mem = 1'b0;
		done = 1'b0;
		wait_n = 0;
		first_resp = -1;
		while (!done) begin
			@(negedge clk);
			wait_n++;
			if (rd_valid || wb_valid)
				saw_mem = 1'b1;
			if (resp_valid && first_resp < 0)
				first_resp = wait_n;
			if (resp_valid && resp_ready)
				done = 1'b1;
		end
		if (!write) begin
			assert (resp_data === expect_data) else begin
				$display("CHECK FAILED at %0d ns: op %0d load 0x%08h returned 0x%016h, expected 0x%016h",
					$time, idx, addr, resp_data, expect_data);
				data_errors++;
			end
		end
		if (must_hit) begin
			assert (!saw_mem) else begin
				$display("CHECK FAILED at %0d ns: op %0d to 0x%08h went to memory on a hit",
					$time, idx, addr);
				data_errors++;
			end
			assert (first_resp == 2) else begin
				$display("CHECK FAILED at %0d ns: op %0d hit answered after %0d cycles, expected 2",
					$time, idx, first_resp);
				data_errors++;
			end
		end
	endtask

	initial begin : main
		int count;
		rst = 1'b1;
		req_valid = 1'b0;
		req_write = 1'b0;
		req_addr = '0;
		req_wstrb = '0;
		req_wdata = '0;
		// unused slots are marked by an all-ones upper half
		for (int i = 0; i < STIM_MAX*5; i++)
			stim[i] = {32'hffffffff, 32'(i)};
		$readmemh("sim/cache_stim.txt", stim);
		count = 0;
		while (count < STIM_MAX && stim[count*5][63:32] != 32'hffffffff)
			count++;
		n_ops = count;
		assert (n_ops > 0) else begin
			$display("no operations found in the stimulus file");
			proto_errors++;
		end
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		for (int i = 0; i < n_ops; i++)
			run_op(i);
		repeat (4) @(posedge clk);
		report_counts();
		if (data_errors == 0 && proto_errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	// memory side: random readies, refill beats and write-back capture
	initial begin : memory_side
		logic rd_fire;
		logic wb_fire;
		cache_pkg::addr_t refill_addr;
		int beats_left;
		int beat_wait;
		resp_ready = 1'b0;
		rd_ready = 1'b0;
		wb_ready = 1'b0;
		rd_data_valid = 1'b0;
		rd_data_last = 1'b0;
		rd_data = '0;
		refill_addr = '0;
		beats_left = 0;
		beat_wait = 0;
		forever begin
			@(negedge clk);
			rd_fire = !rst && rd_valid && rd_ready;
			wb_fire = !rst && wb_valid && wb_ready;
			if (rd_fire) begin
				assert (rd_addr == {cur_addr[31:4], 4'h0}) else begin
					$display("CHECK FAILED at %0d ns: refill address 0x%08h, expected 0x%08h",
						$time, rd_addr, {cur_addr[31:4], 4'h0});
					data_errors++;
				end
				refill_addr = rd_addr;
			end
			if (wb_fire)
				check_writeback();
			@(posedge clk);
			#1;
			rd_data_valid = 1'b0;
			rd_data_last = 1'b0;
			if (beats_left > 0) begin
				if (beat_wait > 0) begin
					beat_wait--;
				end else begin
					// low word first
					rd_data_valid = 1'b1;
					rd_data = memory_word(refill_addr + 32'(8 * (2 - beats_left)));
					rd_data_last = (beats_left == 1);
					beats_left--;
				end
			end
			if (rd_fire) begin
				beats_left = 2;
				beat_wait = int'(next_random_bit());
				beat_wait = beat_wait * 2 + int'(next_random_bit());
			end
			resp_ready = next_random_bit();
			rd_ready = next_random_bit();
			wb_ready = next_random_bit();
		end
	end

	// a valid that is not taken must stay with the same payload
	initial begin : handshake_monitor
		logic resp_wait;
		logic rd_wait;
		logic wb_wait;
		cache_pkg::word_t resp_data_q;
		cache_pkg::addr_t rd_addr_q;
		cache_pkg::addr_t wb_addr_q;
		cache_pkg::block_t wb_data_q;
		resp_wait = 1'b0;
		rd_wait = 1'b0;
		wb_wait = 1'b0;
		forever begin
			@(negedge clk);
			if (resp_wait) begin
				assert (resp_valid && resp_data == resp_data_q) else begin
					$display("response changed before resp_ready at %0d ns", $time);
					proto_errors++;
				end
			end
			if (rd_wait) begin
				assert (rd_valid && rd_addr == rd_addr_q) else begin
					$display("refill request changed before rd_ready at %0d ns", $time);
					proto_errors++;
				end
			end
			if (wb_wait) begin
				assert (wb_valid && wb_addr == wb_addr_q && wb_data == wb_data_q) else begin
					$display("write-back changed before wb_ready at %0d ns", $time);
					proto_errors++;
				end
			end
			resp_wait = !rst && resp_valid && !resp_ready;
			rd_wait = !rst && rd_valid && !rd_ready;
			wb_wait = !rst && wb_valid && !wb_ready;
			resp_data_q = resp_data;
			rd_addr_q = rd_addr;
			wb_addr_q = wb_addr;
			wb_data_q = wb_data;
		end
	end

	initial begin : watchdog
		wait (n_ops > 0);
		#(n_ops * CYCLES_PER_OP * CLK_PERIOD);
		$display("timeout: the operations did not finish within %0d cycles",
			n_ops * CYCLES_PER_OP);
		report_counts();
		$display("Verification failed");
		$finish;
	end

endmodule

//--- compile.f
+incdir+include
hdl/cache_pkg.sv
hdl/sync_ram.sv
hdl/cache_way.sv
hdl/store_buffer.sv
hdl/cache_ctrl.sv
hdl/cache_top.sv
sim/tb_cache.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		--top-module tb_cache -f compile.f
	./obj_dir/Vtb_cache | tee sim.log
	grep -qx "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- sim/cache_stim.txt
// op (bit 0 store, bit 1 must hit), byte address, strobe, store data, expected load data
// unwritten words read as {cafe0000 + A[31:16], A}, merged with earlier stores
0 00001010 00 0000000000000000 cafe000000001010
2 00001018 00 0000000000000000 cafe000000001018
2 00001010 00 0000000000000000 cafe000000001010
3 00001018 0f 1122334455667788 0000000000000000
2 00001018 00 0000000000000000 cafe000055667788
1 00025020 f0 aabbccddeeff0011 0000000000000000
2 00025028 00 0000000000000000 cafe000200025028
2 00025020 00 0000000000000000 aabbccdd00025020
1 00100030 ff 0101010101010101 0000000000000000
1 00200038 ff 0202020202020202 0000000000000000
1 00300030 3c 0303030303030303 0000000000000000
0 00100030 00 0000000000000000 0101010101010101
2 00100038 00 0000000000000000 cafe001000100038
0 00200038 00 0000000000000000 0202020202020202
2 00200030 00 0000000000000000 cafe002000200030
0 00300030 00 0000000000000000 cafe030303030030
2 00300038 00 0000000000000000 cafe003000300038
1 00100038 80 ee00000000000000 0000000000000000
0 00200038 00 0000000000000000 0202020202020202
0 00100038 00 0000000000000000 eefe001000100038
0 00300030 00 0000000000000000 cafe030303030030
2 00001010 00 0000000000000000 cafe000000001010
3 00001010 01 00000000000000ab 0000000000000000
2 00001010 00 0000000000000000 cafe0000000010ab
2 00001018 00 0000000000000000 cafe000055667788
0 fff01050 00 0000000000000000 cafefff0fff01050
2 fff01058 00 0000000000000000 cafefff0fff01058
